// File: csr_block.f
verilog/csr_pkg.sv
verilog/csr_wb_slave.sv
verilog/csr_regs.sv
verilog/csr_irq_unit.sv
verilog/csr_top.sv
test/tb_clock.sv
test/tb_csr_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the CSR block testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
TOP=tb_csr_top

verilator --binary --timing --assert \
  --top-module "$TOP" \
  --Mdir "$OBJ_DIR" -o "$TOP" \
  -f csr_block.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi

exit 0

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #(PERIOD_NS / 2.0);
    clk = ~clk;
  end

endmodule

// File: test/tb_csr_top.sv
`timescale 1ns/1ps

module tb_csr_top;

  localparam int            NUM_EVENTS       = 4;
  localparam csr_pkg::cfg_t CFG_RESET        = 16'h3C5A;
  localparam int            CLK_PERIOD_NS    = 4;
  localparam int            RESET_CYCLES     = 5;
  localparam int            NUM_TRANS        = 400;
  localparam int            CYCLES_PER_TRANS = 10;
  localparam int            RESP_LIMIT       = 8;
  localparam int            TIMEOUT_NS       =
    (NUM_TRANS * CYCLES_PER_TRANS + RESET_CYCLES) * CLK_PERIOD_NS;

  logic                  clk;
  logic                  i_rst_n;
  csr_pkg::wb_req_t      wb_req;
  csr_pkg::wb_rsp_t      wb_rsp;
  logic [NUM_EVENTS-1:0] i_events;
  csr_pkg::mode_t        o_mode;
  csr_pkg::cfg_t         o_cfg;
  logic [NUM_EVENTS-1:0] o_trigger;
  logic                  o_irq;

  int errors     = 0;
  int resp_count = 0;
  logic events_on = 1'b0;

  // Register model
  csr_pkg::mode_t        mode_m;
  logic                  lock_m;
  csr_pkg::cfg_t         cfg_m;
  logic [NUM_EVENTS-1:0] irq_en_m;
  logic [NUM_EVENTS-1:0] status_m;
  logic [NUM_EVENTS-1:0] ev_last;

  tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) u_clock (.clk(clk));

  csr_top #(
    .NUM_EVENTS (NUM_EVENTS),
    .CFG_RESET  (CFG_RESET)
  ) dut (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_wb      (wb_req),
    .o_wb      (wb_rsp),
    .i_events  (i_events),
    .o_mode    (o_mode),
    .o_cfg     (o_cfg),
    .o_trigger (o_trigger),
    .o_irq     (o_irq)
  );

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("error at %0t ns: %s (got 0x%08h, expected 0x%08h)",
               $time, what, actual, expected);
    end
  endtask

  function automatic csr_pkg::data_t byte_mask(input csr_pkg::sel_t sel);
    csr_pkg::data_t mask;
    for (int b = 0; b < 4; b++) begin
      mask[b*8 +: 8] = {8{sel[b]}};
    end
    return mask;
  endfunction

  function automatic csr_pkg::data_t model_read(input csr_pkg::addr_t adr);
    case (adr)
      8'h00:   return {27'd0, lock_m, mode_m};
      8'h04:   return {16'd0, cfg_m};
      8'h08:   return 32'(status_m);
      8'h0C:   return 32'(irq_en_m);
      8'h14:   return csr_pkg::CSR_ID_VALUE;
      default: return '0;
    endcase
  endfunction

  // Mostly mapped words, some misaligned, unmapped or fully random addresses
  function automatic csr_pkg::addr_t random_addr();
    int unsigned pick;
    pick = $urandom % 16;
    if (pick < 12) begin
      return 8'((pick % 6) * 4);
    end else if (pick < 14) begin
      return 8'(($urandom % 6) * 4 + 1 + $urandom % 3);
    end else if (pick == 14) begin
      return 8'h18 + 8'(($urandom % 2) * 4);
    end
    return 8'($urandom);
  endfunction

  task automatic bus_access(input logic we, input csr_pkg::addr_t adr,
                            input csr_pkg::data_t dat, input csr_pkg::sel_t sel);
    int start;
    int waited;
    start = resp_count;
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    waited = 0;
    while (resp_count == start && waited < RESP_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (resp_count == start) begin
      errors++;
      $display("No ack or err came back for the access to 0x%02h", adr);
    end
    wb_req <= '0;
  endtask

  // Sparse random event pulses
  always @(posedge clk) begin
    if (events_on) begin
      i_events <= NUM_EVENTS'($urandom) & NUM_EVENTS'($urandom) & NUM_EVENTS'($urandom);
    end else begin
      i_events <= '0;
    end
  end

  // Outputs are sampled mid-cycle, the model follows each accepted access
  always @(negedge clk) begin : monitor
    csr_pkg::data_t        wmask;
    csr_pkg::data_t        wdata_m;
    csr_pkg::data_t        next_word;
    logic [NUM_EVENTS-1:0] clr;
    logic [NUM_EVENTS-1:0] trig_exp;
    logic                  good_addr;
    if (!i_rst_n) begin
      mode_m   = '0;
      lock_m   = 1'b0;
      cfg_m    = CFG_RESET;
      irq_en_m = '0;
      status_m = '0;
      ev_last  = '0;
    end else begin
      clr      = '0;
      trig_exp = '0;
      if (wb_rsp.ack || wb_rsp.err) begin
        resp_count++;
        good_addr = (wb_req.adr[1:0] == 2'b00) && (wb_req.adr < 8'h18);
        if (!(wb_req.cyc && wb_req.stb)) begin
          errors++;
          $display("A response came with no bus request in progress");
        end
        check_equal(32'(wb_rsp.ack), 32'(good_addr), $sformatf("ack at 0x%02h", wb_req.adr));
        check_equal(32'(wb_rsp.err), 32'(!good_addr), $sformatf("err at 0x%02h", wb_req.adr));
        if (good_addr && wb_rsp.ack && !wb_req.we) begin
          check_equal(wb_rsp.dat, model_read(wb_req.adr),
                      $sformatf("read data at 0x%02h", wb_req.adr));
        end else if (good_addr && wb_rsp.ack) begin
          wmask   = byte_mask(wb_req.sel);
          wdata_m = wb_req.dat & wmask;
          case (wb_req.adr)
            8'h00: begin
              next_word = (model_read(8'h00) & ~wmask) | wdata_m;
              mode_m    = next_word[3:0];
              lock_m    = lock_m | next_word[4];
            end
            8'h04: begin
              next_word = (model_read(8'h04) & ~wmask) | wdata_m;
              if (!lock_m) begin
                cfg_m = next_word[15:0];
              end
            end
            8'h08: clr = wdata_m[NUM_EVENTS-1:0];
            8'h0C: begin
              next_word = (model_read(8'h0C) & ~wmask) | wdata_m;
              irq_en_m  = next_word[NUM_EVENTS-1:0];
            end
            8'h10: trig_exp = wdata_m[NUM_EVENTS-1:0];
            default: ;
          endcase
        end
      end
      // An event sampled at the same edge wins over the clear
      status_m = (status_m & ~clr) | ev_last;
      ev_last  = i_events;
      check_equal(32'(o_trigger), 32'(trig_exp), "o_trigger");
      check_equal(32'(o_irq), 32'(|(status_m & irq_en_m)), "o_irq");
      check_equal(32'(o_mode), 32'(mode_m), "o_mode");
      check_equal(32'(o_cfg), 32'(cfg_m), "o_cfg");
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    csr_pkg::addr_t adr;
    csr_pkg::data_t dat;
    logic           we;
    void'($urandom(32'h2311_53f4));
    i_rst_n  = 1'b0;
    wb_req   = '0;
    i_events = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    i_rst_n <= 1'b1;

    for (int a = 0; a < 6; a++) begin
      bus_access(1'b0, 8'(a * 4), '0, 4'hF);
    end

    events_on <= 1'b1;
    for (int i = 0; i < 240; i++) begin
      adr = random_addr();
      we  = ($urandom % 2) == 1;
      dat = $urandom;
      // Keep lock clear until the lock test
      if (adr == 8'h00) begin
        dat[4] = 1'b0;
      end
      bus_access(we, adr, dat, 4'($urandom));
    end

    events_on <= 1'b0;
    repeat (3) @(posedge clk);
    bus_access(1'b0, 8'h08, '0, 4'hF);
    bus_access(1'b1, 8'h08, 32'hFFFF_FFFF, 4'h1);
    bus_access(1'b0, 8'h08, '0, 4'hF);

    bus_access(1'b1, 8'h00, 32'h0000_0010, 4'h1);
    for (int i = 0; i < 30; i++) begin
      bus_access(1'b1, 8'h04, $urandom, 4'($urandom));
      bus_access(1'b1, 8'h00, $urandom & 32'hFFFF_FFEF, 4'hF);
      bus_access(1'b0, 8'h04, '0, 4'hF);
      bus_access(1'b0, 8'h00, '0, 4'hF);
    end

    repeat (3) @(posedge clk);
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/csr_irq_unit.sv
`timescale 1ns/1ps

module csr_irq_unit #(
  parameter int NUM_EVENTS = 4
) (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic [NUM_EVENTS-1:0] i_events,
  input  logic [NUM_EVENTS-1:0] i_clear,
  input  logic [NUM_EVENTS-1:0] i_enable,
  output logic [NUM_EVENTS-1:0] o_status,
  output logic                  o_irq
);

  logic [NUM_EVENTS-1:0] status_q;
  logic [NUM_EVENTS-1:0] pending;

  // New events win over a clear in the same cycle
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~i_clear) | i_events;
    end
  end

  assign pending  = status_q & i_enable;
  assign o_irq    = |pending;
  assign o_status = status_q;

  for (genvar i = 0; i < NUM_EVENTS; i++) begin : g_sticky
    a_sticky: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      (status_q[i] && !i_clear[i]) |=> status_q[i]
    );
  end

endmodule

// File: verilog/csr_pkg.sv
package csr_pkg;

  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;
  localparam int SEL_WIDTH  = DATA_WIDTH / 8;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [SEL_WIDTH-1:0]  sel_t;
  typedef logic [2:0]            reg_index_t;
  typedef logic [3:0]            mode_t;
  typedef logic [15:0]           cfg_t;

  // Wishbone classic request, held by the master until ack or err
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat;
    sel_t  sel;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    logic  err;
    data_t dat;
  } wb_rsp_t;

  // One register access, valid for a single cycle
  typedef struct packed {
    logic       valid;
    logic       write;
    reg_index_t index;
    data_t      wdata;
    sel_t       sel;
  } reg_access_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } reg_rsp_t;

  // Word indices, byte address divided by four
  localparam reg_index_t IDX_CTRL       = 3'd0;
  localparam reg_index_t IDX_CFG        = 3'd1;
  localparam reg_index_t IDX_STATUS     = 3'd2;
  localparam reg_index_t IDX_IRQ_ENABLE = 3'd3;
  localparam reg_index_t IDX_TRIGGER    = 3'd4;
  localparam reg_index_t IDX_ID         = 3'd5;

  localparam data_t CSR_ID_VALUE = 32'hC5B0_0104;

  // Mode occupies the bits below lock
  localparam int CTRL_LOCK_BIT = 4;

endpackage

// File: verilog/csr_regs.sv
`timescale 1ns/1ps

module csr_regs #(
  parameter int            NUM_EVENTS = 4,
  parameter csr_pkg::cfg_t CFG_RESET  = 16'h00A5
) (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  csr_pkg::reg_access_t   i_access,
  output csr_pkg::reg_rsp_t      o_rsp,
  input  logic [NUM_EVENTS-1:0]  i_status,
  output logic [NUM_EVENTS-1:0]  o_status_clear,
  output logic [NUM_EVENTS-1:0]  o_irq_enable,
  output csr_pkg::mode_t         o_mode,
  output csr_pkg::cfg_t          o_cfg,
  output logic [NUM_EVENTS-1:0]  o_trigger
);

  localparam int MODE_W = $bits(csr_pkg::mode_t);
  localparam int CFG_W  = $bits(csr_pkg::cfg_t);

  csr_pkg::mode_t        mode_q;
  logic                  lock_q;
  csr_pkg::cfg_t         cfg_q;
  logic [NUM_EVENTS-1:0] irq_en_q;
  logic [NUM_EVENTS-1:0] trigger_q;

  logic wr;
  logic wr_ctrl;
  logic wr_cfg;
  logic wr_status;
  logic wr_irq_en;
  logic wr_trigger;

  csr_pkg::data_t strobe_mask;
  csr_pkg::data_t wsel_data;
  csr_pkg::data_t ctrl_word;
  csr_pkg::data_t cfg_word;
  csr_pkg::data_t irq_en_word;
  csr_pkg::data_t status_word;
  csr_pkg::data_t ctrl_wr;
  csr_pkg::data_t cfg_wr;
  csr_pkg::data_t irq_en_wr;

  assign wr         = i_access.valid && i_access.write;
  assign wr_ctrl    = wr && (i_access.index == csr_pkg::IDX_CTRL);
  assign wr_cfg     = wr && (i_access.index == csr_pkg::IDX_CFG);
  assign wr_status  = wr && (i_access.index == csr_pkg::IDX_STATUS);
  assign wr_irq_en  = wr && (i_access.index == csr_pkg::IDX_IRQ_ENABLE);
  assign wr_trigger = wr && (i_access.index == csr_pkg::IDX_TRIGGER);

  // Expand byte selects to a bit mask
  always_comb begin
    for (int b = 0; b < $bits(csr_pkg::sel_t); b++) begin
      strobe_mask[b*8 +: 8] = {8{i_access.sel[b]}};
    end
  end

  assign wsel_data = i_access.wdata & strobe_mask;

  always_comb begin
    ctrl_word                      = '0;
    ctrl_word[MODE_W-1:0]          = mode_q;
    ctrl_word[csr_pkg::CTRL_LOCK_BIT] = lock_q;
    cfg_word                       = '0;
    cfg_word[CFG_W-1:0]            = cfg_q;
    irq_en_word                    = '0;
    irq_en_word[NUM_EVENTS-1:0]    = irq_en_q;
    status_word                    = '0;
    status_word[NUM_EVENTS-1:0]    = i_status;
  end

  // Unselected bytes keep their current value
  assign ctrl_wr   = (ctrl_word & ~strobe_mask) | wsel_data;
  assign cfg_wr    = (cfg_word & ~strobe_mask) | wsel_data;
  assign irq_en_wr = (irq_en_word & ~strobe_mask) | wsel_data;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      mode_q    <= '0;
      lock_q    <= 1'b0;
      cfg_q     <= CFG_RESET;
      irq_en_q  <= '0;
      trigger_q <= '0;
    end else begin
      if (wr_ctrl) begin
        mode_q <= ctrl_wr[MODE_W-1:0];
        // Lock only sets, reset is the only way out
        lock_q <= lock_q | ctrl_wr[csr_pkg::CTRL_LOCK_BIT];
      end
      if (wr_cfg && !lock_q) begin
        cfg_q <= cfg_wr[CFG_W-1:0];
      end
      if (wr_irq_en) begin
        irq_en_q <= irq_en_wr[NUM_EVENTS-1:0];
      end
      trigger_q <= wr_trigger ? wsel_data[NUM_EVENTS-1:0] : '0;
    end
  end

  // W1C pulses act at the write edge
  assign o_status_clear = wr_status ? wsel_data[NUM_EVENTS-1:0] : '0;

  always_comb begin
    o_rsp.rdata = '0;
    o_rsp.err   = 1'b0;
    case (i_access.index)
      csr_pkg::IDX_CTRL:       o_rsp.rdata = ctrl_word;
      csr_pkg::IDX_CFG:        o_rsp.rdata = cfg_word;
      csr_pkg::IDX_STATUS:     o_rsp.rdata = status_word;
      csr_pkg::IDX_IRQ_ENABLE: o_rsp.rdata = irq_en_word;
      csr_pkg::IDX_TRIGGER:    o_rsp.rdata = '0;
      csr_pkg::IDX_ID:         o_rsp.rdata = csr_pkg::CSR_ID_VALUE;
      default:                 o_rsp.err   = 1'b1;
    endcase
  end

  assign o_irq_enable = irq_en_q;
  assign o_mode       = mode_q;
  assign o_cfg        = cfg_q;
  assign o_trigger    = trigger_q;

  a_cfg_locked: assert property (
    @(posedge clk) disable iff (!i_rst_n) lock_q |=> $stable(o_cfg)
  );

endmodule

// File: verilog/csr_top.sv
`timescale 1ns/1ps

module csr_top #(
  parameter int            NUM_EVENTS = 4,
  parameter csr_pkg::cfg_t CFG_RESET  = 16'h00A5
) (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  csr_pkg::wb_req_t      i_wb,
  output csr_pkg::wb_rsp_t      o_wb,
  input  logic [NUM_EVENTS-1:0] i_events,
  output csr_pkg::mode_t        o_mode,
  output csr_pkg::cfg_t         o_cfg,
  output logic [NUM_EVENTS-1:0] o_trigger,
  output logic                  o_irq
);

  csr_pkg::reg_access_t  reg_access;
  csr_pkg::reg_rsp_t     reg_rsp;
  logic [NUM_EVENTS-1:0] status;
  logic [NUM_EVENTS-1:0] status_clear;
  logic [NUM_EVENTS-1:0] irq_enable;

  csr_wb_slave u_wb_slave (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_wb     (i_wb),
    .o_wb     (o_wb),
    .o_access (reg_access),
    .i_rsp    (reg_rsp)
  );

  csr_regs #(
    .NUM_EVENTS (NUM_EVENTS),
    .CFG_RESET  (CFG_RESET)
  ) u_regs (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_access       (reg_access),
    .o_rsp          (reg_rsp),
    .i_status       (status),
    .o_status_clear (status_clear),
    .o_irq_enable   (irq_enable),
    .o_mode         (o_mode),
    .o_cfg          (o_cfg),
    .o_trigger      (o_trigger)
  );

  csr_irq_unit #(
    .NUM_EVENTS (NUM_EVENTS)
  ) u_irq_unit (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_events (i_events),
    .i_clear  (status_clear),
    .i_enable (irq_enable),
    .o_status (status),
    .o_irq    (o_irq)
  );

endmodule

// File: verilog/csr_wb_slave.sv
`timescale 1ns/1ps

module csr_wb_slave (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  csr_pkg::wb_req_t     i_wb,
  output csr_pkg::wb_rsp_t     o_wb,
  output csr_pkg::reg_access_t o_access,
  input  csr_pkg::reg_rsp_t    i_rsp
);

  localparam int IDX_LSB = 2;
  localparam int IDX_MSB = IDX_LSB + $bits(csr_pkg::reg_index_t) - 1;

  // RESP is the ack/err cycle, GAP waits for the master to drop stb
  typedef enum logic [1:0] {
    S_IDLE,
    S_RESP,
    S_GAP
  } state_e;

  state_e         state_q;
  logic           req;
  logic           misaligned;
  logic           out_of_range;
  logic           bad_addr;
  logic           ack_q;
  logic           err_q;
  csr_pkg::data_t dat_q;

  assign req          = i_wb.cyc && i_wb.stb && (state_q == S_IDLE);
  assign misaligned   = |i_wb.adr[IDX_LSB-1:0];
  // Upper address bits do not fit the word index
  assign out_of_range = |i_wb.adr[csr_pkg::ADDR_WIDTH-1:IDX_MSB+1];
  assign bad_addr     = misaligned || out_of_range;

  always_comb begin
    o_access.valid = req && !bad_addr;
    o_access.write = i_wb.we;
    o_access.index = i_wb.adr[IDX_MSB:IDX_LSB];
    o_access.wdata = i_wb.dat;
    o_access.sel   = i_wb.sel;
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (req) begin
            state_q <= S_RESP;
          end
        end
        S_RESP: begin
          state_q <= S_GAP;
        end
        default: begin
          if (!(i_wb.cyc && i_wb.stb)) begin
            state_q <= S_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req && !bad_addr && !i_rsp.err;
      err_q <= req && (bad_addr || i_rsp.err);
    end
  end

  // Read data only for a good read, zero otherwise
  always_ff @(posedge clk) begin
    if (req) begin
      if (!i_wb.we && !bad_addr && !i_rsp.err) begin
        dat_q <= i_rsp.rdata;
      end else begin
        dat_q <= '0;
      end
    end
  end

  always_comb begin
    o_wb.ack = ack_q;
    o_wb.err = err_q;
    o_wb.dat = dat_q;
  end

  // A response belongs to the RESP state and is never ack and err together
  a_ack_err_excl: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (ack_q || err_q) |-> (state_q == S_RESP) && !(ack_q && err_q)
  );

  a_ack_one_cycle: assert property (
    @(posedge clk) disable iff (!i_rst_n) ack_q |=> !ack_q
  );

  a_err_one_cycle: assert property (
    @(posedge clk) disable iff (!i_rst_n) err_q |=> !err_q
  );

endmodule
